/* common/conv_defs.svh */
//////////////////////////////////////////////////
// widths, memory depths and context field offsets
// for the convolution tile; include where needed
//////////////////////////////////////////////////
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

`define LINE_BITS            128
`define LANE_BITS            32
`define LANES                (`LINE_BITS / `LANE_BITS)
`define ADDR_BITS            32
// bit 0 of the tag carries the request kind
`define MDATA_BITS           4
`define CONTEXT_BITS         128

`define CTX_IMAGE_LSB        0
`define CTX_FILTER_LSB       32
`define CTX_DEST_LSB         64
`define CTX_NUM_IN_LSB       96
`define CTX_NUM_OUT_LSB      104

`define IMAGE_DEPTH_BITS     4
`define KERNEL_DEPTH_BITS    6
`define OUT_FIFO_DEPTH_BITS  3
// free entries left when the output FIFO reports almost full
`define OUT_FIFO_ALMOST_FULL 4

`endif

/* common/conv_pkg.sv */
//////////////////////////////////////////////////
// shared types of the convolution tile
// referenced as conv_pkg::name from every module
//////////////////////////////////////////////////
`default_nettype none

`include "conv_defs.svh"

package conv_pkg;

  typedef logic [`LANE_BITS-1:0] lane_t;
  typedef lane_t [`LANES-1:0] line_t;
  typedef logic [`ADDR_BITS-1:0] addr_t;
  typedef logic [7:0] count_t;

  // carried in mdata bit 0
  typedef enum logic {
    REQ_IMAGE  = 1'b0,
    REQ_KERNEL = 1'b1
  } req_kind_t;

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_KERNEL,
    RD_IMAGE_WAIT,
    RD_IMAGE,
    RD_FINISH
  } read_state_t;

  typedef enum logic [1:0] {
    VACANT,
    FILL,
    FULL,
    DRAIN
  } bank_status_t;

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_RUN,
    EX_DRAIN
  } exec_state_t;

endpackage

`default_nettype wire

/* read_path/read_requester.sv */
//////////////////////////////////////////////////
// latches the job context, requests all kernel
// lines and then the image tiles bank by bank,
// and steers tagged read responses to memories
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module read_requester (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic [`CONTEXT_BITS-1:0]  afu_context,
  input  logic                      rd_req_almostfull,
  input  logic                      rd_rsp_valid,
  input  logic [`MDATA_BITS-1:0]    rd_rsp_mdata,
  input  conv_pkg::line_t           rd_rsp_data,
  input  logic                      bank_free,
  output conv_pkg::addr_t           rd_req_addr,
  output logic [`MDATA_BITS-1:0]    rd_req_mdata,
  output logic                      rd_req_en,
  output logic                      tile_claim,
  output logic                      image_we,
  output logic                      kernel_we,
  output conv_pkg::line_t           rsp_line,
  output conv_pkg::count_t          num_in,
  output conv_pkg::count_t          num_out,
  output conv_pkg::addr_t           dest_base,
  output conv_pkg::addr_t           out_lines
);

  conv_pkg::read_state_t state;
  conv_pkg::addr_t image_addr;
  conv_pkg::addr_t filter_base;
  conv_pkg::addr_t filter_addr;
  conv_pkg::addr_t kernel_end;
  conv_pkg::addr_t div_left;
  conv_pkg::count_t line_cnt;
  conv_pkg::addr_t ctx_image;
  conv_pkg::addr_t ctx_filter;
  conv_pkg::count_t ctx_num_in;
  conv_pkg::count_t ctx_num_out;

  assign ctx_image   = afu_context[`CTX_IMAGE_LSB +: `ADDR_BITS];
  assign ctx_filter  = afu_context[`CTX_FILTER_LSB +: `ADDR_BITS];
  assign ctx_num_in  = afu_context[`CTX_NUM_IN_LSB +: 8];
  assign ctx_num_out = afu_context[`CTX_NUM_OUT_LSB +: 8];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= conv_pkg::RD_IDLE;
      rd_req_en <= 1'b0;
      tile_claim <= 1'b0;
    end else if (start) begin
      image_addr <= ctx_image;
      filter_base <= ctx_filter;
      filter_addr <= ctx_filter;
      kernel_end <= ctx_filter + conv_pkg::addr_t'(ctx_num_in) * conv_pkg::addr_t'(ctx_num_out);
      dest_base <= afu_context[`CTX_DEST_LSB +: `ADDR_BITS];
      num_in <= ctx_num_in;
      num_out <= ctx_num_out;
      rd_req_en <= 1'b0;
      tile_claim <= 1'b0;
      state <= conv_pkg::RD_KERNEL;
    end else begin
      rd_req_en <= 1'b0;
      tile_claim <= 1'b0;
      case (state)
        conv_pkg::RD_KERNEL: begin
          if (filter_addr == kernel_end) begin
            state <= conv_pkg::RD_IMAGE_WAIT;
          end else if (!rd_req_almostfull) begin
            rd_req_addr <= filter_addr;
            rd_req_mdata <= {{(`MDATA_BITS-1){1'b0}}, conv_pkg::REQ_KERNEL};
            rd_req_en <= 1'b1;
            filter_addr <= filter_addr + 1'b1;
          end
        end
        // a whole tile goes into one bank, so wait for a vacant one
        conv_pkg::RD_IMAGE_WAIT: begin
          if (image_addr == filter_base) begin
            state <= conv_pkg::RD_FINISH;
          end else if (bank_free) begin
            tile_claim <= 1'b1;
            line_cnt <= '0;
            state <= conv_pkg::RD_IMAGE;
          end
        end
        conv_pkg::RD_IMAGE: begin
          if (!rd_req_almostfull) begin
            rd_req_addr <= image_addr;
            rd_req_mdata <= {{(`MDATA_BITS-1){1'b0}}, conv_pkg::REQ_IMAGE};
            rd_req_en <= 1'b1;
            image_addr <= image_addr + 1'b1;
            line_cnt <= line_cnt + 1'b1;
            if (line_cnt == num_in - 8'd1) begin
              state <= conv_pkg::RD_IMAGE_WAIT;
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  // tile count times D2 by repeated subtraction, one tile per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      div_left <= '0;
      out_lines <= '0;
    end else if (start) begin
      div_left <= ctx_filter - ctx_image;
      out_lines <= '0;
    end else if (div_left != '0) begin
      div_left <= div_left - conv_pkg::addr_t'(num_in);
      out_lines <= out_lines + conv_pkg::addr_t'(num_out);
    end
  end

  // responses come back in request order
  always_ff @(posedge clk) begin
    if (reset) begin
      image_we <= 1'b0;
      kernel_we <= 1'b0;
    end else begin
      image_we <= rd_rsp_valid &&
                  (conv_pkg::req_kind_t'(rd_rsp_mdata[0]) == conv_pkg::REQ_IMAGE);
      kernel_we <= rd_rsp_valid &&
                   (conv_pkg::req_kind_t'(rd_rsp_mdata[0]) == conv_pkg::REQ_KERNEL);
    end
  end

  always_ff @(posedge clk) begin
    rsp_line <= rd_rsp_data;
  end

endmodule

`default_nettype wire

/* read_path/image_buffer.sv */
//////////////////////////////////////////////////
// two-bank image memory; one bank fills from the
// read responses while the other one is drained
// by the execution sequencer
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module image_buffer (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic                          image_we,
  input  conv_pkg::line_t               rsp_line,
  input  conv_pkg::count_t              num_in,
  input  logic                          tile_claim,
  input  logic                          tile_take,
  input  logic                          tile_release,
  input  logic [`IMAGE_DEPTH_BITS-1:0]  rd_addr,
  output logic                          bank_free,
  output logic                          tile_ready,
  output conv_pkg::line_t               image_line
);

  conv_pkg::line_t mem [0:1][0:(1 << `IMAGE_DEPTH_BITS)-1];
  conv_pkg::bank_status_t status [0:1];
  logic wr_bank;
  logic rd_bank;
  logic [`IMAGE_DEPTH_BITS-1:0] wr_cnt;
  logic fill_done;

  // last line of the tile lands in the write bank
  assign fill_done = image_we && (conv_pkg::count_t'(wr_cnt) == num_in - 8'd1);

  assign bank_free = (status[wr_bank] == conv_pkg::VACANT);
  assign tile_ready = (status[rd_bank] == conv_pkg::FULL);

  always_ff @(posedge clk) begin
    if (reset || start) begin
      wr_bank <= 1'b0;
      rd_bank <= 1'b0;
      wr_cnt <= '0;
      status[0] <= conv_pkg::VACANT;
      status[1] <= conv_pkg::VACANT;
    end else begin
      if (image_we) begin
        wr_cnt <= fill_done ? '0 : wr_cnt + 1'b1;
      end
      if (fill_done) begin
        wr_bank <= ~wr_bank;
      end
      if (tile_release) begin
        rd_bank <= ~rd_bank;
      end
      // each event only matches a bank in the state it leaves
      for (int b = 0; b < 2; b++) begin
        case (status[b])
          conv_pkg::VACANT: if (tile_claim && wr_bank == b[0]) status[b] <= conv_pkg::FILL;
          conv_pkg::FILL:   if (fill_done && wr_bank == b[0]) status[b] <= conv_pkg::FULL;
          conv_pkg::FULL:   if (tile_take && rd_bank == b[0]) status[b] <= conv_pkg::DRAIN;
          conv_pkg::DRAIN:  if (tile_release && rd_bank == b[0]) status[b] <= conv_pkg::VACANT;
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (image_we) begin
      mem[wr_bank][wr_cnt] <= rsp_line;
    end
    image_line <= mem[rd_bank][rd_addr];
  end

endmodule

`default_nettype wire

/* source/kernel_store.sv */
//////////////////////////////////////////////////
// kernel line memory, loaded once per job in
// filter order and read by the sequencer
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module kernel_store (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           start,
  input  logic                           kernel_we,
  input  conv_pkg::line_t                rsp_line,
  input  conv_pkg::count_t               num_in,
  input  conv_pkg::count_t               num_out,
  input  logic [`KERNEL_DEPTH_BITS-1:0]  rd_addr,
  output logic                           kernels_loaded,
  output conv_pkg::line_t                kernel_line
);

  conv_pkg::line_t mem [0:(1 << `KERNEL_DEPTH_BITS)-1];
  logic [`KERNEL_DEPTH_BITS:0] wr_cnt;
  logic [15:0] total;

  assign total = num_in * num_out;

  always_ff @(posedge clk) begin
    if (reset || start) begin
      wr_cnt <= '0;
      kernels_loaded <= 1'b0;
    end else begin
      if (kernel_we) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      kernels_loaded <= (16'(wr_cnt) == total);
    end
  end

  always_ff @(posedge clk) begin
    if (kernel_we) begin
      mem[wr_cnt[`KERNEL_DEPTH_BITS-1:0]] <= rsp_line;
    end
    kernel_line <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* exec/exec_sequencer.sv */
//////////////////////////////////////////////////
// walks a full image tile against the kernels of
// every output map and paces the MAC array; holds
// between maps while the output FIFO is near full
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module exec_sequencer (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           tile_ready,
  input  logic                           kernels_loaded,
  input  conv_pkg::count_t               num_in,
  input  conv_pkg::count_t               num_out,
  input  logic                           fifo_almost_full,
  output logic                           tile_take,
  output logic                           tile_release,
  output logic [`IMAGE_DEPTH_BITS-1:0]   image_rd_addr,
  output logic [`KERNEL_DEPTH_BITS-1:0]  kernel_rd_addr,
  output logic                           mac_step,
  output logic                           mac_last
);

  conv_pkg::exec_state_t state;
  logic [`IMAGE_DEPTH_BITS-1:0] m;
  logic [`KERNEL_DEPTH_BITS-1:0] kbase;
  conv_pkg::count_t k;
  logic step_raw;
  logic last_raw;
  logic map_end;

  assign map_end = (conv_pkg::count_t'(m) == num_in - 8'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= conv_pkg::EX_IDLE;
      tile_take <= 1'b0;
      tile_release <= 1'b0;
      step_raw <= 1'b0;
      last_raw <= 1'b0;
    end else begin
      tile_take <= 1'b0;
      tile_release <= 1'b0;
      step_raw <= 1'b0;
      last_raw <= 1'b0;
      case (state)
        conv_pkg::EX_IDLE: begin
          if (tile_ready && kernels_loaded && !fifo_almost_full) begin
            tile_take <= 1'b1;
            m <= '0;
            k <= '0;
            kbase <= '0;
            state <= conv_pkg::EX_RUN;
          end
        end
        conv_pkg::EX_RUN: begin
          step_raw <= 1'b1;
          last_raw <= map_end;
          image_rd_addr <= m;
          kernel_rd_addr <= kbase + `KERNEL_DEPTH_BITS'(m);
          if (map_end) begin
            m <= '0;
            kbase <= kbase + num_in[`KERNEL_DEPTH_BITS-1:0];
            k <= k + 8'd1;
            state <= conv_pkg::EX_DRAIN;
          end else begin
            m <= m + 1'b1;
          end
        end
        // map boundary, the next map waits for FIFO room
        conv_pkg::EX_DRAIN: begin
          if (k == num_out) begin
            tile_release <= 1'b1;
            state <= conv_pkg::EX_IDLE;
          end else if (!fifo_almost_full) begin
            state <= conv_pkg::EX_RUN;
          end
        end
        default: begin
          state <= conv_pkg::EX_IDLE;
        end
      endcase
    end
  end

  // line up with the synchronous memory reads
  always_ff @(posedge clk) begin
    if (reset) begin
      mac_step <= 1'b0;
      mac_last <= 1'b0;
    end else begin
      mac_step <= step_raw;
      mac_last <= last_raw;
    end
  end

endmodule

`default_nettype wire

/* exec/mac_array.sv */
//////////////////////////////////////////////////
// lane-wise multiply and accumulate; one result
// line per output map, two cycles after mac_last
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module mac_array (
  input  logic             clk,
  input  logic             reset,
  input  conv_pkg::line_t  image_line,
  input  conv_pkg::line_t  kernel_line,
  input  logic             mac_step,
  input  logic             mac_last,
  output conv_pkg::line_t  out_line,
  output logic             out_valid
);

  conv_pkg::line_t prod;
  logic prod_valid;
  logic prod_last;
  logic fresh;

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      prod_last <= 1'b0;
      out_valid <= 1'b0;
      fresh <= 1'b1;
    end else begin
      prod_valid <= mac_step;
      prod_last <= mac_step && mac_last;
      out_valid <= prod_valid && prod_last;
      if (prod_valid) begin
        fresh <= prod_last;
      end
    end
  end

  // sums wrap modulo 2^32 per lane
  always_ff @(posedge clk) begin
    for (int j = 0; j < `LANES; j++) begin
      prod[j] <= image_line[j] * kernel_line[j];
      if (prod_valid) begin
        out_line[j] <= fresh ? prod[j] : out_line[j] + prod[j];
      end
    end
  end

endmodule

`default_nettype wire

/* source/write_requester.sv */
//////////////////////////////////////////////////
// output FIFO between the MAC array and the write
// port; issues writes to consecutive destination
// lines and raises done after the last one
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module write_requester (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  conv_pkg::line_t  out_line,
  input  logic             out_valid,
  input  conv_pkg::addr_t  dest_base,
  input  conv_pkg::addr_t  out_lines,
  input  logic             wr_req_almostfull,
  output conv_pkg::addr_t  wr_req_addr,
  output conv_pkg::line_t  wr_req_data,
  output logic             wr_req_en,
  output logic             fifo_almost_full,
  output logic             done
);

  conv_pkg::line_t fifo_mem [0:(1 << `OUT_FIFO_DEPTH_BITS)-1];
  logic [`OUT_FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [`OUT_FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic [`OUT_FIFO_DEPTH_BITS:0] count;
  logic fifo_re;
  conv_pkg::addr_t wr_cnt;

  assign fifo_re = (count != '0) && !wr_req_almostfull;
  assign fifo_almost_full = (count >= (1 << `OUT_FIFO_DEPTH_BITS) - `OUT_FIFO_ALMOST_FULL);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      wr_req_en <= 1'b0;
    end else begin
      wr_req_en <= fifo_re;
      if (out_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (fifo_re) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({out_valid, fifo_re})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: begin
        end
      endcase
    end
  end

  // wr_cnt counts FIFO reads, so it is ahead of wr_req_en by one
  always_ff @(posedge clk) begin
    if (reset || start) begin
      wr_cnt <= '0;
      done <= 1'b0;
    end else begin
      if (fifo_re) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      if (wr_req_en && wr_cnt == out_lines) begin
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_valid) begin
      fifo_mem[wr_ptr] <= out_line;
    end
    if (fifo_re) begin
      wr_req_data <= fifo_mem[rd_ptr];
      wr_req_addr <= dest_base + wr_cnt;
    end
  end

endmodule

`default_nettype wire

/* source/conv_afu_top.sv */
//////////////////////////////////////////////////
// convolution tile top level behind a cacheline
// memory port; software starts a job with start
// and the context vector, done marks the end
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv_afu_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic [`CONTEXT_BITS-1:0]  afu_context,
  output conv_pkg::addr_t           rd_req_addr,
  output logic [`MDATA_BITS-1:0]    rd_req_mdata,
  output logic                      rd_req_en,
  input  logic                      rd_req_almostfull,
  input  logic                      rd_rsp_valid,
  input  logic [`MDATA_BITS-1:0]    rd_rsp_mdata,
  input  conv_pkg::line_t           rd_rsp_data,
  output conv_pkg::addr_t           wr_req_addr,
  output conv_pkg::line_t           wr_req_data,
  output logic                      wr_req_en,
  input  logic                      wr_req_almostfull,
  output logic                      done
);

  // read side to the memories
  logic tile_claim;
  logic image_we;
  logic kernel_we;
  conv_pkg::line_t rsp_line;
  conv_pkg::count_t num_in;
  conv_pkg::count_t num_out;
  conv_pkg::addr_t dest_base;
  conv_pkg::addr_t out_lines;

  // tile handshake and memory reads
  logic bank_free;
  logic tile_ready;
  logic tile_take;
  logic tile_release;
  logic kernels_loaded;
  logic [`IMAGE_DEPTH_BITS-1:0] image_rd_addr;
  logic [`KERNEL_DEPTH_BITS-1:0] kernel_rd_addr;
  conv_pkg::line_t image_line;
  conv_pkg::line_t kernel_line;

  // datapath to the write side
  logic mac_step;
  logic mac_last;
  conv_pkg::line_t out_line;
  logic out_valid;
  logic fifo_almost_full;

  read_requester u_read_requester (.*);

  image_buffer u_image_buffer (
    .*,
    .rd_addr (image_rd_addr)
  );

  kernel_store u_kernel_store (
    .*,
    .rd_addr (kernel_rd_addr)
  );

  exec_sequencer u_exec_sequencer (.*);

  mac_array u_mac_array (.*);

  write_requester u_write_requester (.*);

endmodule

`default_nettype wire

/* sim/conv_afu_checker.sv */
//////////////////////////////////////////////////
// protocol assertions on the top level ports of
// the convolution tile, attached with bind
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module conv_afu_checker (
  input logic clk,
  input logic reset,
  input logic start,
  input logic rd_req_en,
  input logic rd_req_almostfull,
  input logic wr_req_en,
  input logic wr_req_almostfull,
  input logic done
);

  // sticky flag, watched by the testbench
  logic failed = 1'b0;

  // a request needs room at the edge before it
  rd_after_room: assert property (@(posedge clk) disable iff (reset)
    rd_req_en |-> !$past(rd_req_almostfull))
    else begin
      failed = 1'b1;
      $error("read request issued after an almost-full cycle");
    end

  wr_after_room: assert property (@(posedge clk) disable iff (reset)
    wr_req_en |-> !$past(wr_req_almostfull))
    else begin
      failed = 1'b1;
      $error("write request issued after an almost-full cycle");
    end

  // done only clears on the next start
  done_holds: assert property (@(posedge clk) disable iff (reset)
    (done && !start) |=> done)
    else begin
      failed = 1'b1;
      $error("done dropped without a start");
    end

  done_after_last_write: assert property (@(posedge clk) disable iff (reset)
    $rose(done) |-> ($past(wr_req_en) && !wr_req_en))
    else begin
      failed = 1'b1;
      $error("done did not follow the last write by one cycle");
    end

endmodule

`default_nettype wire

/* sim/conv_afu_tb.sv */
//////////////////////////////////////////////////
// testbench for the convolution tile: in-order
// memory model, random almost-full, two jobs with
// a scoreboard of the lane-wise MAC results
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "conv_defs.svh"

module conv_afu_tb;

  // job 1 has several input maps and job 2 a single one for fast outputs
  localparam int J1_IMAGE = 32'h100;
  localparam int J1_TILES = 3;
  localparam int J1_D1 = 4;
  localparam int J1_D2 = 3;
  localparam int J1_DEST = 32'h8000;
  localparam int J2_IMAGE = 32'h200;
  localparam int J2_TILES = 4;
  localparam int J2_D1 = 1;
  localparam int J2_D2 = 5;
  localparam int J2_DEST = 32'h9000;
  localparam int J1_LINES = J1_TILES * J1_D1 + J1_D1 * J1_D2 + J1_TILES * J1_D2;
  localparam int J2_LINES = J2_TILES * J2_D1 + J2_D1 * J2_D2 + J2_TILES * J2_D2;
  localparam int TIMEOUT_CYCLES = 40 * (J1_LINES + J2_LINES) + 1000;

  logic clk = 1'b0;
  logic reset;
  logic start;
  logic [`CONTEXT_BITS-1:0] afu_context;
  conv_pkg::addr_t rd_req_addr;
  logic [`MDATA_BITS-1:0] rd_req_mdata;
  logic rd_req_en;
  logic rd_req_almostfull;
  logic rd_rsp_valid;
  logic [`MDATA_BITS-1:0] rd_rsp_mdata;
  conv_pkg::line_t rd_rsp_data;
  conv_pkg::addr_t wr_req_addr;
  conv_pkg::line_t wr_req_data;
  logic wr_req_en;
  logic wr_req_almostfull;
  logic done;

  // memory image and scoreboard state
  conv_pkg::line_t mem [0:1023];
  int req_seen [0:1023];
  int wr_seen [0:63];
  int addr_q[$];
  logic [`MDATA_BITS-1:0] tag_q[$];
  logic [15:0] lfsr_state;
  int job_image;
  int job_filter;
  int job_kernel_end;
  int job_d1;
  int job_d2;
  int job_dest;
  int job_lines;
  int writes_seen;
  bit image_started;
  logic rd_af_prev = 1'b0;
  logic wr_af_prev = 1'b0;
  logic done_prev = 1'b0;

  conv_afu_top DUT (.*);

  bind conv_afu_top conv_afu_checker u_checker (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .rd_req_en         (rd_req_en),
    .rd_req_almostfull (rd_req_almostfull),
    .wr_req_en         (wr_req_en),
    .wr_req_almostfull (wr_req_almostfull),
    .done              (done)
  );

  always #10 clk = ~clk;

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    assert (actual === expected) else begin
      $display("FAILED at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("ERROR at %0t ns: %s", $time, what);
      stop_with_failure();
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[15]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  task automatic fill_region(input int first, input int count);
    for (int a = first; a < first + count; a++) begin
      for (int j = 0; j < `LANES; j++) begin
        mem[a][j] = take_bits(32);
      end
    end
  endtask

  function automatic logic [`CONTEXT_BITS-1:0] make_context(input int image, input int filter,
                                                            input int dest, input int d1,
                                                            input int d2);
    logic [`CONTEXT_BITS-1:0] ctx;
    ctx = '0;
    ctx[`CTX_IMAGE_LSB +: `ADDR_BITS] = image;
    ctx[`CTX_FILTER_LSB +: `ADDR_BITS] = filter;
    ctx[`CTX_DEST_LSB +: `ADDR_BITS] = dest;
    ctx[`CTX_NUM_IN_LSB +: 8] = 8'(d1);
    ctx[`CTX_NUM_OUT_LSB +: 8] = 8'(d2);
    return ctx;
  endfunction

  // offset o is tile o / D2 and map o % D2
  function automatic conv_pkg::line_t expected_line(input int o);
    int tile;
    int map;
    conv_pkg::line_t img;
    conv_pkg::line_t ker;
    conv_pkg::line_t acc;
    tile = o / job_d2;
    map = o % job_d2;
    acc = '0;
    for (int m = 0; m < job_d1; m++) begin
      img = mem[job_image + tile * job_d1 + m];
      ker = mem[job_filter + map * job_d1 + m];
      for (int j = 0; j < `LANES; j++) begin
        acc[j] = acc[j] + img[j] * ker[j];
      end
    end
    return acc;
  endfunction

  task automatic note_read(input conv_pkg::addr_t addr, input logic [`MDATA_BITS-1:0] tag);
    bit is_kernel;
    check_true(!rd_af_prev, "read request issued after an almost-full cycle");
    check_true(addr >= job_image && addr < job_kernel_end, "read outside the job regions");
    is_kernel = (addr >= job_filter);
    check_value("rd_req_mdata[0]", is_kernel, tag[0]);
    if (is_kernel) begin
      check_true(!image_started, "kernel read requested after image reads began");
    end else begin
      image_started = 1'b1;
    end
    check_true(req_seen[addr] == 0, "address requested more than once");
    req_seen[addr]++;
    addr_q.push_back(int'(addr));
    tag_q.push_back(tag);
  endtask

  task automatic note_write(input conv_pkg::addr_t addr, input conv_pkg::line_t data);
    conv_pkg::addr_t off;
    off = addr - conv_pkg::addr_t'(job_dest);
    check_true(!wr_af_prev, "write request issued after an almost-full cycle");
    check_true(off < job_lines, "write outside the destination range");
    check_true(wr_seen[off] == 0, "destination line written twice");
    check_value("wr_req_data", expected_line(int'(off)), data);
    wr_seen[off]++;
    writes_seen++;
  endtask

  // sample outputs at the edge before they update
  always @(posedge clk) begin
    if (!reset) begin
      check_true(!DUT.u_checker.failed, "a bound protocol assertion failed");
      if (rd_req_en) begin
        note_read(rd_req_addr, rd_req_mdata);
      end
      if (wr_req_en) begin
        note_write(wr_req_addr, wr_req_data);
      end
      if (done && !done_prev) begin
        check_value("writes before done", job_lines, writes_seen);
      end
    end
    rd_af_prev = rd_req_almostfull;
    wr_af_prev = wr_req_almostfull;
    done_prev = done;
  end

  // memory model answers in request order with random gaps
  always @(posedge clk) begin
    #2;
    rd_req_almostfull = (take_bits(2) == 0);
    wr_req_almostfull = (take_bits(1) == 0);
    if (addr_q.size() != 0 && take_bits(2) != 0) begin
      rd_rsp_valid = 1'b1;
      rd_rsp_data = mem[addr_q.pop_front()];
      rd_rsp_mdata = tag_q.pop_front();
    end else begin
      rd_rsp_valid = 1'b0;
    end
  end

  task automatic run_job(input int image, input int tiles, input int d1, input int d2,
                         input int dest);
    job_image = image;
    job_filter = image + tiles * d1;
    job_kernel_end = job_filter + d1 * d2;
    job_d1 = d1;
    job_d2 = d2;
    job_dest = dest;
    job_lines = tiles * d2;
    writes_seen = 0;
    image_started = 1'b0;
    foreach (req_seen[a]) req_seen[a] = 0;
    foreach (wr_seen[o]) wr_seen[o] = 0;
    @(posedge clk);
    #2;
    afu_context = make_context(image, job_filter, dest, d1, d2);
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    check_value("done", 0, done);
    while (!done) @(posedge clk);
    // let any stray write show up
    repeat (20) @(posedge clk);
    #2;
    for (int a = job_image; a < job_kernel_end; a++) begin
      check_true(req_seen[a] == 1, "an image or filter line was never requested");
    end
    for (int o = 0; o < job_lines; o++) begin
      check_true(wr_seen[o] == 1, "a destination line was never written");
    end
    check_true(addr_q.size() == 0, "read requests left without a response");
    check_value("done", 1, done);
  endtask

  initial begin
    reset = 1'b1;
    start = 1'b0;
    afu_context = '0;
    rd_req_almostfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_mdata = '0;
    rd_rsp_data = '0;
    wr_req_almostfull = 1'b0;
    lfsr_state = 16'd3732;
    fill_region(J1_IMAGE, J1_TILES * J1_D1 + J1_D1 * J1_D2);
    fill_region(J2_IMAGE, J2_TILES * J2_D1 + J2_D1 * J2_D2);
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    run_job(J1_IMAGE, J1_TILES, J1_D1, J1_D2, J1_DEST);
    run_job(J2_IMAGE, J2_TILES, J2_D1, J2_D2, J2_DEST);
    if (DUT.u_checker.failed) begin
      $display("ERROR at %0t ns: a bound protocol assertion failed", $time);
      stop_with_failure();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: jobs did not finish within %0d cycles", TIMEOUT_CYCLES);
    stop_with_failure();
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/conv_pkg.sv
read_path/read_requester.sv
read_path/image_buffer.sv
source/kernel_store.sv
exec/exec_sequencer.sv
exec/mac_array.sv
source/write_requester.sv
source/conv_afu_top.sv
sim/conv_afu_checker.sv
sim/conv_afu_tb.sv

/* Bender.yml */
package:
  name: conv_afu

export_include_dirs:
  - common

sources:
  - common/conv_pkg.sv
  - read_path/read_requester.sv
  - read_path/image_buffer.sv
  - source/kernel_store.sv
  - exec/exec_sequencer.sv
  - exec/mac_array.sv
  - source/write_requester.sv
  - source/conv_afu_top.sv
  - target: test
    files:
      - sim/conv_afu_checker.sv
      - sim/conv_afu_tb.sv
